// File: all.f
common/dsp_pkg.sv
design/dsp_prog_rom.sv
design/dsp_fetch.sv
dau/dsp_decode.sv
dau/dsp_execute.sv
design/dsp_result.sv
design/dsp_top.sv
verif/dsp_tb.sv

// File: verif/dsp_tb.sv
// Testbench for the DSP core with program loader, output model and port checks
`timescale 1ns/1ps

module dsp_tb;

    import dsp_pkg::*;

    localparam int     ROM_AW      = 10;
    localparam int     X_IMM       = 467;
    localparam int     SAT_TARGET  = 3;
    localparam int     SAT_LIMIT   = 6000;
    localparam int     FAULT_LIMIT = 200;
    localparam longint HI_LIMIT    = 64'sd2147483647;
    localparam longint LO_LIMIT    = -64'sd2147483648;

    logic              clk;
    logic              rst_n;
    logic              run;
    logic [ROM_AW-1:0] prog_addr;
    word_t             prog_data;
    logic              prog_we;
    word_t             pbus_in;
    word_t             pbus_out;
    logic              pods_n;
    logic              pids_n;
    logic              psel;
    logic              fault;

    integer seed;
    integer rnd;
    int     y_val;
    longint prod_val;
    longint model_acc [2];
    word_t  exp_word;
    logic   exp_chan;
    logic   next_chan;
    int     sat_count [2];
    int     pids_falls;
    int     mismatch_count;
    int     fail_count;
    logic   running;
    bit     timed_out;

    dsp_top #(.ROM_AW(ROM_AW)) dut_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .run       ( run       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .pbus_in   ( pbus_in   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .pids_n    ( pids_n    ),
        .psel      ( psel      ),
        .fault     ( fault     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction encodings
    function automatic word_t imm_word(op_e op, int imm);
        return {op, 2'b00, imm[9:0]};
    endfunction

    function automatic word_t acc_word(op_e op, logic acc_sel, logic chan);
        return {op, acc_sel, chan, 10'b0};
    endfunction

    // High word of the accumulator clipped to the 16-bit range
    function automatic word_t expected_high_word(longint acc);
        if (acc > HI_LIMIT) begin
            return SAT_POS;
        end else if (acc < LO_LIMIT) begin
            return SAT_NEG;
        end
        return acc[31:16];
    endfunction

    task write_word(int addr, word_t data);
        @(posedge clk);
        prog_addr <= addr[ROM_AW-1:0];
        prog_data <= data;
        prog_we   <= 1'b1;
    endtask

    task finish_loading();
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task wait_saturated();
        int cycles;
        cycles = 0;
        while ((sat_count[0] < SAT_TARGET || sat_count[1] < SAT_TARGET) &&
               cycles < SAT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (sat_count[0] < SAT_TARGET || sat_count[1] < SAT_TARGET) begin
            fail_count++;
            timed_out = 1'b1;
            $display("timeout: outputs did not saturate within %0d cycles", SAT_LIMIT);
        end
    endtask

    task wait_fault();
        int cycles;
        cycles = 0;
        while (!fault && cycles < FAULT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fault) begin
            fail_count++;
            timed_out = 1'b1;
            $display("timeout: fault did not rise within %0d cycles", FAULT_LIMIT);
        end
    endtask

    // Output model adding one product per MAC on the channel that is due next
    always @(negedge pods_n) begin
        if (rst_n === 1'b1) begin
            model_acc[next_chan] = model_acc[next_chan] + prod_val;
            exp_word = expected_high_word(model_acc[next_chan]);
            exp_chan = next_chan;
            if (model_acc[next_chan] > HI_LIMIT || model_acc[next_chan] < LO_LIMIT) begin
                sat_count[next_chan]++;
            end
            next_chan = ~next_chan;
        end
    end

    always @(negedge pids_n) begin
        if (rst_n === 1'b1) begin
            pids_falls++;
        end
    end

    check_pbus: assert property (@(posedge clk) disable iff (!rst_n)
        !pods_n |-> pbus_out == exp_word)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: pbus_out got %h expected %h",
                 $time, $sampled(pbus_out), $sampled(exp_word));
    end

    check_psel: assert property (@(posedge clk) disable iff (!rst_n)
        !pods_n |-> psel == exp_chan)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: psel got %b expected %b",
                 $time, $sampled(psel), $sampled(exp_chan));
    end

    pods_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pods_n) |=> pods_n)
    else begin
        fail_count++;
        $display("pods_n stayed low longer than one cycle at %0t", $time);
    end

    pids_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pids_n) |=> pids_n)
    else begin
        fail_count++;
        $display("pids_n stayed low longer than one cycle at %0t", $time);
    end

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pods_n) |-> $stable(pbus_out) && $stable(psel))
    else begin
        fail_count++;
        $display("pbus_out or psel changed as the strobe ended at %0t", $time);
    end

    fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> fault)
    else begin
        fail_count++;
        $display("fault dropped without a reset at %0t", $time);
    end

    quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !running |-> pods_n && pids_n && !fault && pbus_out == '0)
    else begin
        fail_count++;
        $display("port or fault activity while the core was idle at %0t", $time);
    end

    initial begin
        seed      = 93226;
        rnd       = $random(seed);
        // Magnitude of at least 0x4000 so that saturation comes early
        pbus_in   = {rnd[15], ~rnd[15], rnd[13:0]};
        y_val     = int'($signed(pbus_in));
        prod_val  = longint'(X_IMM) * longint'(y_val);
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        running   = 1'b0;
        timed_out = 1'b0;
        exp_word  = '0;
        exp_chan  = 1'b0;
        next_chan = 1'b0;
        model_acc[0]   = 0;
        model_acc[1]   = 0;
        sat_count[0]   = 0;
        sat_count[1]   = 0;
        pids_falls     = 0;
        mismatch_count = 0;
        fail_count     = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        write_word(0, imm_word(LDX, X_IMM));
        write_word(1, acc_word(IN, 1'b0, 1'b0));
        write_word(2, acc_word(NOP, 1'b0, 1'b0));
        write_word(3, acc_word(MPY, 1'b0, 1'b0));
        write_word(4, acc_word(CLR, 1'b0, 1'b0));
        write_word(5, acc_word(CLR, 1'b1, 1'b0));
        write_word(6, acc_word(MAC, 1'b0, 1'b0));
        write_word(7, acc_word(OUT, 1'b0, 1'b0));
        write_word(8, acc_word(MAC, 1'b1, 1'b0));
        write_word(9, acc_word(OUT, 1'b1, 1'b1));
        write_word(10, imm_word(GOTO, 6));
        // Flushed slot where an extra MAC would break the sequence
        write_word(11, acc_word(MAC, 1'b0, 1'b0));
        finish_loading();

        @(posedge clk);
        run     <= 1'b1;
        running <= 1'b1;
        wait_saturated();

        if (!timed_out) begin
            // Only defined opcodes have run so far
            no_early_fault: assert (!fault) else begin
                fail_count++;
                $display("fault rose before any undefined opcode ran");
            end
            // Redirect the loop to an undefined opcode
            @(posedge clk);
            run <= 1'b0;
            write_word(12, 16'hB000);
            write_word(13, imm_word(GOTO, 12));
            write_word(10, imm_word(GOTO, 12));
            finish_loading();
            @(posedge clk);
            run <= 1'b1;
            wait_fault();
        end

        if (!timed_out) begin
            repeat (20) @(posedge clk);
            check_pids_once: assert (pids_falls == 1) else begin
                fail_count++;
                $display("pids_n pulsed %0d times instead of once", pids_falls);
            end
            @(posedge clk);
            run     <= 1'b0;
            rst_n   <= 1'b0;
            running <= 1'b0;
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            fault_cleared: assert (!fault) else begin
                fail_count++;
                $display("fault still set after reset");
            end
            repeat (4) @(posedge clk);
        end

        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: design/dsp_top.sv
// Core top level connecting program memory, fetch, decode, execute and result
`timescale 1ns/1ps

module dsp_top #(
    parameter int ROM_AW = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    // Program loading
    input  logic [ROM_AW-1:0] prog_addr,
    input  dsp_pkg::word_t    prog_data,
    input  logic              prog_we,
    // Parallel port
    input  dsp_pkg::word_t    pbus_in,
    output dsp_pkg::word_t    pbus_out,
    output logic              pods_n,
    output logic              pids_n,
    output logic              psel,
    output logic              fault
);

    import dsp_pkg::*;

    logic [ROM_AW-1:0] pc;
    logic [ROM_AW-1:0] jump_addr;
    logic              jump;
    logic              instr_valid;
    word_t             rom_data;
    dec_ctrl_t         ctrl;
    out_req_t          out_req;

    dsp_prog_rom #(.ROM_AW(ROM_AW)) u_rom (
        .clk       ( clk       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .rd_addr   ( pc        ),
        .rd_data   ( rom_data  )
    );

    dsp_fetch #(.ROM_AW(ROM_AW)) u_fetch (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .run         ( run         ),
        .jump        ( jump        ),
        .jump_addr   ( jump_addr   ),
        .pc          ( pc          ),
        .instr_valid ( instr_valid )
    );

    dsp_decode #(.ROM_AW(ROM_AW)) u_decode (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .instr       ( rom_data    ),
        .instr_valid ( instr_valid ),
        .ctrl        ( ctrl        ),
        .jump        ( jump        ),
        .jump_addr   ( jump_addr   ),
        .fault       ( fault       )
    );

    dsp_execute u_execute (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .ctrl    ( ctrl    ),
        .pbus_in ( pbus_in ),
        .pids_n  ( pids_n  ),
        .out_req ( out_req )
    );

    dsp_result u_result (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .out_req  ( out_req  ),
        .pbus_out ( pbus_out ),
        .pods_n   ( pods_n   ),
        .psel     ( psel     )
    );

endmodule

// File: design/dsp_result.sv
// Output saturation and parallel port output strobe and channel select
`timescale 1ns/1ps

module dsp_result (
    input  logic              clk,
    input  logic              rst_n,
    input  dsp_pkg::out_req_t out_req,
    output dsp_pkg::word_t    pbus_out,
    output logic              pods_n,
    output logic              psel
);

    import dsp_pkg::*;

    logic  ovf;
    word_t sat_word;

    // Bits 35 to 31 must agree for the high word to be exact
    assign ovf = (|out_req.acc[35:31]) & ~(&out_req.acc[35:31]);

    always_comb begin
        if (ovf) begin
            sat_word = out_req.acc[35] ? SAT_NEG : SAT_POS;
        end else begin
            sat_word = out_req.acc[31:16];
        end
    end

    // Strobe lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pods_n <= 1'b1;
        end else begin
            pods_n <= ~out_req.valid;
        end
    end

    // Data and select hold until the next OUT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pbus_out <= '0;
            psel     <= 1'b0;
        end else if (out_req.valid) begin
            pbus_out <= sat_word;
            psel     <= out_req.chan;
        end
    end

endmodule

// File: dau/dsp_execute.sv
// Data arithmetic unit with x, y, product, two accumulators and the input strobe
`timescale 1ns/1ps

module dsp_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  dsp_pkg::dec_ctrl_t ctrl,
    input  dsp_pkg::word_t     pbus_in,
    output logic               pids_n,
    output dsp_pkg::out_req_t  out_req
);

    import dsp_pkg::*;

    word_t x;
    word_t y;
    prod_t p;
    acc_t  a0;
    acc_t  a1;
    acc_t  acc_cur;
    acc_t  p_ext;
    acc_t  acc_next;

    // Accumulator picked by the instruction
    assign acc_cur = ctrl.acc_sel ? a1 : a0;

    // Product sign-extended by 4 guard bits so the sum wraps at 36 bits
    assign p_ext = {{4{p[31]}}, p};

    always_comb begin
        if (ctrl.clr) begin
            acc_next = '0;
        end else begin
            acc_next = acc_cur + p_ext;
        end
    end

    // Input strobe goes low for one cycle per IN
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pids_n <= 1'b1;
        end else begin
            pids_n <= ~ctrl.load_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
            p <= '0;
        end else begin
            if (ctrl.load_x) begin
                x <= ctrl.imm;
            end
            // Sample the port as the strobe ends
            if (!pids_n) begin
                y <= pbus_in;
            end
            // A later LDY overrides the port sample
            if (ctrl.load_y) begin
                y <= ctrl.imm;
            end
            if (ctrl.mpy) begin
                p <= $signed(x) * $signed(y);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a0 <= '0;
            a1 <= '0;
        end else if (ctrl.mac || ctrl.clr) begin
            if (ctrl.acc_sel) begin
                a1 <= acc_next;
            end else begin
                a0 <= acc_next;
            end
        end
    end

    // OUT hands the accumulator to the result stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req <= '0;
        end else begin
            out_req.valid <= ctrl.out;
            out_req.acc   <= acc_cur;
            out_req.chan  <= ctrl.chan;
        end
    end

endmodule

// File: dau/dsp_decode.sv
// Instruction decode into execute controls, jump request and sticky fault
`timescale 1ns/1ps

module dsp_decode #(
    parameter int ROM_AW = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  dsp_pkg::instr_u    instr,
    input  logic               instr_valid,
    output dsp_pkg::dec_ctrl_t ctrl,
    output logic               jump,
    output logic [ROM_AW-1:0]  jump_addr,
    output logic               fault
);

    import dsp_pkg::*;

    op_e       op;
    dec_ctrl_t ctrl_next;
    logic      undef_op;

    // Both views keep the opcode in the same place
    assign op = instr.imm_view.op;

    always_comb begin
        ctrl_next         = '0;
        undef_op          = 1'b0;
        // Operands follow the word and only the strobes are qualified
        ctrl_next.acc_sel = instr.acc_view.acc_sel;
        ctrl_next.chan    = instr.acc_view.chan;
        ctrl_next.imm     = {{6{instr.imm_view.imm[9]}}, instr.imm_view.imm};
        if (instr_valid) begin
            case (op)
                NOP:  ;
                LDX:  ctrl_next.load_x  = 1'b1;
                LDY:  ctrl_next.load_y  = 1'b1;
                MPY:  ctrl_next.mpy     = 1'b1;
                MAC:  ctrl_next.mac     = 1'b1;
                CLR:  ctrl_next.clr     = 1'b1;
                OUT:  ctrl_next.out     = 1'b1;
                IN:   ctrl_next.load_in = 1'b1;
                GOTO: ;
                default: undef_op = 1'b1;
            endcase
        end
    end

    // Taken straight from the memory output so that only one word is flushed
    assign jump      = instr_valid && (op == GOTO);
    assign jump_addr = ROM_AW'(instr.imm_view.imm);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

    // Stays set until the next reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (undef_op) begin
            fault <= 1'b1;
        end
    end

endmodule

// File: design/dsp_fetch.sv
// Program counter, run control, jump handling and instruction valid flag
`timescale 1ns/1ps

module dsp_fetch #(
    parameter int ROM_AW = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    // Jump request from decode
    input  logic              jump,
    input  logic [ROM_AW-1:0] jump_addr,
    // To the program memory and decode
    output logic [ROM_AW-1:0] pc,
    output logic              instr_valid
);

    logic [ROM_AW-1:0] pc_next;

    // Jump wins over the sequential step
    always_comb begin
        if (jump) begin
            pc_next = jump_addr;
        end else if (run) begin
            pc_next = pc + 1'b1;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Valid travels alongside the memory read of the current pc.
    // The word read while a jump is taken is already stale, so it is dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= run & ~jump;
        end
    end

endmodule

// File: design/dsp_prog_rom.sv
// Program memory with a load port and a registered fetch port
`timescale 1ns/1ps

module dsp_prog_rom #(
    parameter int ROM_AW = 10
) (
    input  logic              clk,
    // Loading port, used while the core is stopped
    input  logic [ROM_AW-1:0] prog_addr,
    input  dsp_pkg::word_t    prog_data,
    input  logic              prog_we,
    // Fetch port
    input  logic [ROM_AW-1:0] rd_addr,
    output dsp_pkg::word_t    rd_data
);

    import dsp_pkg::*;

    localparam int DEPTH = 1 << ROM_AW;

    word_t mem [DEPTH];

    // Loader writes
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // One cycle read latency, matched by the valid flag in fetch
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: common/dsp_pkg.sv
// Word, product and accumulator types, opcodes, instruction views and stage structs
package dsp_pkg;

    typedef logic [15:0]        word_t;
    typedef logic signed [31:0] prod_t;
    typedef logic signed [35:0] acc_t;

    // Output port limits
    localparam word_t SAT_POS = 16'h7FFF;
    localparam word_t SAT_NEG = 16'h8000;

    // Codes 9 to 15 are undefined and raise the fault flag
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        LDX  = 4'd1,
        LDY  = 4'd2,
        MPY  = 4'd3,
        MAC  = 4'd4,
        CLR  = 4'd5,
        OUT  = 4'd6,
        IN   = 4'd7,
        GOTO = 4'd8
    } op_e;

    // Immediate view, for LDX, LDY and GOTO
    typedef struct packed {
        op_e        op;
        logic [1:0] spare;
        logic [9:0] imm;
    } instr_imm_t;

    // Accumulator view, for MAC, CLR and OUT
    typedef struct packed {
        op_e        op;
        logic       acc_sel;
        logic       chan;
        logic [9:0] spare;
    } instr_acc_t;

    typedef union packed {
        instr_imm_t imm_view;
        instr_acc_t acc_view;
    } instr_u;

    // Decode to execute, one-hot strobes plus operands
    typedef struct packed {
        logic  load_x;
        logic  load_y;
        logic  load_in;
        logic  mpy;
        logic  mac;
        logic  clr;
        logic  out;
        logic  acc_sel;
        logic  chan;
        word_t imm;
    } dec_ctrl_t;

    // Execute to result
    typedef struct packed {
        logic valid;
        acc_t acc;
        logic chan;
    } out_req_t;

endpackage
